// File: build.f
+incdir+.
fpu_types_pkg.sv
fpu_io_pkg.sv
fpu_recode_in.sv
fpu_compare_rec.sv
fpu_fmin_fmax.sv
fpu_recode_out.sv
fpu_cmp_unit.sv
fpu_cmp_unit_asserts.sv
tb_fpu_cmp_unit.sv

// File: run.sh
#!/bin/sh
# compile the compare unit testbench with Verilator and run it
# exit status 0 only when the simulation log holds the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_fpu_cmp_unit \
  -f build.f --Mdir obj_dir -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "STATUS: PASS" sim.log; then
  exit 0
fi
exit 1

// File: tb_fpu_cmp_unit.sv
// testbench for the floating-point compare unit
// directed, nan, random and back-pressure traffic over the four-phase handshake
// expected values come from a reference model on the ieee bit fields

`timescale 1ns/1ns
`include "fpu_settings.svh"

module tb_fpu_cmp_unit;

  import fpu_types_pkg::*;
  import fpu_io_pkg::*;

  localparam int unsigned word_w   = `FPU_EXP_WIDTH + `FPU_SIG_WIDTH;
  localparam int unsigned max_wait = 50;

  logic        clk_i;
  logic        rst_n_i;
  logic        req_i;
  fpu_req_t    req_data_i;
  logic        ack_o;
  fpu_rsp_t    rsp_o;

  // requests waiting for their response
  fpu_req_t    sent_q[$];
  int unsigned n_sent;
  int unsigned n_checked;

  // zeros, normals, subnormals, infinities, quiet and signaling nans
  logic [word_w-1:0] dir_vals [16] = '{
    32'h0000_0000, 32'h8000_0000, 32'h3f80_0000, 32'h4000_0000,
    32'hbfc0_0000, 32'hc040_0000, 32'h0000_0001, 32'h8000_0010,
    32'h007f_ffff, 32'h0080_0000, 32'h7f80_0000, 32'hff80_0000,
    32'h7fc0_0001, 32'hffc1_2345, 32'h7f80_0001, 32'hff80_0abc
  };

  fpu_cmp_unit i_dut (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (req_i),
    .req_data_i (req_data_i),
    .ack_o      (ack_o),
    .rsp_o      (rsp_o)
  );

  always #5 clk_i = ~clk_i;

  // ---------------------------------------------------------------------------
  // reference model on the binary32 fields
  // ---------------------------------------------------------------------------
  function automatic fpu_rsp_t fpu_ref(fpu_req_t req);
    fpu_rsp_t          rsp;
    logic [word_w-1:0] a;
    logic [word_w-1:0] b;
    logic              a_nan;
    logic              b_nan;
    logic              a_snan;
    logic              b_snan;
    logic              both_zero;
    logic              lt;
    logic              eq;
    a         = req.rs1;
    b         = req.rs2;
    a_nan     = (a[30:23] == 8'hff) && (a[22:0] != '0);
    b_nan     = (b[30:23] == 8'hff) && (b[22:0] != '0);
    // quiet bit clear
    a_snan    = a_nan && !a[22];
    b_snan    = b_nan && !b[22];
    both_zero = (a[30:0] == '0) && (b[30:0] == '0);
    // sign-magnitude ordering where +0 equals -0
    if (both_zero) begin
      lt = 1'b0;
      eq = 1'b1;
    end else if (a[31] != b[31]) begin
      lt = a[31];
      eq = 1'b0;
    end else if (a[31]) begin
      lt = (a[30:0] > b[30:0]);
      eq = (a == b);
    end else begin
      lt = (a[30:0] < b[30:0]);
      eq = (a == b);
    end
    if (a_nan || b_nan) begin
      lt = 1'b0;
      eq = 1'b0;
    end
    rsp = '0;
    case (req.op)
      FMIN, FMAX: begin
        if (a_nan && b_nan) rsp.result.uint = 32'h7fc0_0000;
        else if (a_nan) rsp.result.uint = b;
        else if (b_nan) rsp.result.uint = a;
        // min keeps the negative zero, max the positive one
        else if (both_zero) rsp.result.uint = ((req.op == FMIN) == a[31]) ? a : b;
        else rsp.result.uint = ((req.op == FMIN) == lt) ? a : b;
        rsp.invalid = a_snan || b_snan;
      end
      FEQ: begin
        rsp.result.uint = {31'd0, eq};
        rsp.invalid     = a_snan || b_snan;
      end
      FLT: begin
        rsp.result.uint = {31'd0, lt};
        rsp.invalid     = a_nan || b_nan;
      end
      FLE: begin
        rsp.result.uint = {31'd0, lt | eq};
        rsp.invalid     = a_nan || b_nan;
      end
      default: rsp = '0;
    endcase
    return rsp;
  endfunction

  // ---------------------------------------------------------------------------
  // checks
  // ---------------------------------------------------------------------------
  task automatic report_failure(input string what);
    $display("%s", what);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_float(input string name, input fpu_result_u exp_v,
                             input fpu_result_u act_v);
    if (act_v.flt !== exp_v.flt) begin
      report_failure($sformatf("[ERROR] %s expected %h actual %h", name, exp_v.flt,
                               act_v.flt));
    end
  endtask

  task automatic check_int(input string name, input fpu_result_u exp_v,
                           input fpu_result_u act_v);
    if (act_v.uint !== exp_v.uint) begin
      report_failure($sformatf("[ERROR] %s expected %h actual %h", name, exp_v.uint,
                               act_v.uint));
    end
  endtask

  task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      report_failure($sformatf("[ERROR] %s expected %h actual %h", name, exp_v, act_v));
    end
  endtask

  // ---------------------------------------------------------------------------
  // four-phase driver with an optional hold of req after ack
  // ---------------------------------------------------------------------------
  task automatic drive_request(input fpu_req_t req, input int unsigned hold_cycles);
    int unsigned edges;
    fpu_rsp_t    exp_rsp;
    req_data_i = req;
    req_i      = 1'b1;
    sent_q.push_back(req);
    n_sent++;
    exp_rsp = fpu_ref(req);
    edges = 0;
    do begin
      @(posedge clk_i);
      #1;
      edges++;
    end while (!ack_o && edges < max_wait);
    if (!ack_o) begin
      report_failure("timeout while waiting for ack_o to rise");
    end else if (edges != 2) begin
      report_failure($sformatf("ack_o rose %0d edges after req_i instead of 2", edges));
    end
    // ack and response hold while req stays high
    for (int i = 0; i < hold_cycles; i++) begin
      @(posedge clk_i);
      #1;
      check_flag("ack_o", 1'b1, ack_o);
      if (req.op == FMIN || req.op == FMAX) begin
        check_float("rsp_o.result.flt (held)", exp_rsp.result, rsp_o.result);
      end else begin
        check_int("rsp_o.result.uint (held)", exp_rsp.result, rsp_o.result);
      end
      check_flag("rsp_o.invalid (held)", exp_rsp.invalid, rsp_o.invalid);
    end
    req_i = 1'b0;
    edges = 0;
    do begin
      @(posedge clk_i);
      #1;
      edges++;
    end while (ack_o && edges < max_wait);
    if (ack_o) begin
      report_failure("timeout while waiting for ack_o to fall");
    end else if (edges != 1) begin
      report_failure($sformatf("ack_o fell %0d edges after req_i dropped instead of 1", edges));
    end
  endtask

  // response check mid-cycle once ack is up
  always @(posedge ack_o) begin : compare_response
    fpu_req_t req;
    fpu_rsp_t exp_rsp;
    string    tag;
    @(negedge clk_i);
    if (sent_q.size() == 0) begin
      report_failure("ack_o rose with no request outstanding");
    end else begin
      req     = sent_q.pop_front();
      exp_rsp = fpu_ref(req);
      tag     = $sformatf("%s %h %h", req.op.name(), req.rs1, req.rs2);
      if (req.op == FMIN || req.op == FMAX) begin
        check_float({"rsp_o.result.flt for ", tag}, exp_rsp.result, rsp_o.result);
      end else begin
        check_int({"rsp_o.result.uint for ", tag}, exp_rsp.result, rsp_o.result);
      end
      check_flag({"rsp_o.invalid for ", tag}, exp_rsp.invalid, rsp_o.invalid);
      n_checked++;
    end
  end

  // ---------------------------------------------------------------------------
  // stimulus
  // ---------------------------------------------------------------------------
  initial begin
    fpu_req_t          req;
    logic [word_w-1:0] a;
    logic [word_w-1:0] b;
    void'($urandom(32'h8ced));
    clk_i      = 1'b0;
    rst_n_i    = 1'b0;
    req_i      = 1'b0;
    req_data_i = '0;
    n_sent     = 0;
    n_checked  = 0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    check_flag("ack_o", 1'b0, ack_o);
    check_int("rsp_o.result", '0, rsp_o.result);
    check_flag("rsp_o.invalid", 1'b0, rsp_o.invalid);

    // every ordered pair under every op covers both operand orders
    foreach (dir_vals[i]) begin
      foreach (dir_vals[j]) begin
        for (int k = 0; k < 5; k++) begin
          req.op  = fpu_op_e'(k[2:0]);
          req.rs1 = dir_vals[i];
          req.rs2 = dir_vals[j];
          drive_request(req, 0);
        end
      end
    end

    // random bit patterns mostly with a shared exponent
    for (int n = 0; n < 300; n++) begin
      a = $urandom();
      b = $urandom();
      if ($urandom_range(3, 0) != 0) b[30:23] = a[30:23];
      req.op  = fpu_op_e'($urandom_range(4, 0));
      req.rs1 = a;
      req.rs2 = b;
      drive_request(req, 0);
    end

    // requester stalls 20 cycles before a normal request follows
    req.op  = FMAX;
    req.rs1 = 32'hc040_0000;
    req.rs2 = 32'h8000_0001;
    drive_request(req, 20);
    req.op  = FLE;
    req.rs1 = 32'h0000_0000;
    req.rs2 = 32'h8000_0000;
    drive_request(req, 0);

    repeat (2) @(posedge clk_i);
    if (n_checked != n_sent || sent_q.size() != 0) begin
      report_failure($sformatf("%0d requests sent but %0d responses checked", n_sent,
                               n_checked));
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

// File: fpu_cmp_unit_asserts.sv
// handshake and reset checks for the compare unit
// bound into every fpu_cmp_unit instance

`timescale 1ns/1ns

module fpu_cmp_unit_asserts (
  input logic                 clk_i,
  input logic                 rst_n_i,
  input logic                 req_i,
  input logic                 ack_i,
  input fpu_io_pkg::fpu_rsp_t rsp_i
);

  // unit idle while reset is held
  ack_low_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !ack_i)
    else $error("ack_o high while rst_n_i is low");

  // ack only answers a pending request
  // req may already be low one edge after ack rose so its past value counts
  ack_rise_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(ack_i) |-> $past(req_i))
    else $error("ack_o rose without req_i high");

  // response frozen for as long as ack stays up
  rsp_stable_during_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ($past(ack_i) && ack_i) |-> $stable(rsp_i))
    else $error("rsp_o changed while ack_o was high");

endmodule

bind fpu_cmp_unit fpu_cmp_unit_asserts i_asserts (
  .clk_i   (clk_i),
  .rst_n_i (rst_n_i),
  .req_i   (req_i),
  .ack_i   (ack_o),
  .rsp_i   (rsp_o)
);

// File: fpu_cmp_unit.sv
// floating-point compare unit: fmin, fmax, feq, flt, fle on binary32
// four-phase req/ack, one operation in flight
// operands registered on accept, result registered one edge later with ack

`timescale 1ns/1ns
`include "fpu_settings.svh"

module fpu_cmp_unit (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 req_i,
  input  fpu_io_pkg::fpu_req_t req_data_i,
  output logic                 ack_o,
  output fpu_io_pkg::fpu_rsp_t rsp_o
);

  import fpu_types_pkg::*;
  import fpu_io_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_BUSY, ST_DONE} state_e;

  state_e   state_q;
  state_e   state_d;
  fpu_req_t req_q;
  fpu_rsp_t rsp_d;

  rec_num_t rs1_rec;
  rec_num_t rs2_rec;
  rec_num_t minmax_rec;
  logic     fmin_sel;
  logic     minmax_invalid;
  logic     cmp_signaling;
  logic     cmp_lt;
  logic     cmp_eq;
  logic     cmp_invalid;
  logic [`FPU_EXP_WIDTH+`FPU_SIG_WIDTH-1:0] minmax_word;

  // ---------------------------------------------------------------------------
  // handshake FSM
  // ---------------------------------------------------------------------------
  // idle -> busy on req, busy -> done unconditionally, done -> idle once req drops
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: if (req_i) state_d = ST_BUSY;
      ST_BUSY: state_d = ST_DONE;
      ST_DONE: if (!req_i) state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // operands latched on accept only
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && req_i) begin
      req_q <= req_data_i;
    end
  end

  // result captured together with the rise of ack
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_o <= '0;
    end else if (state_q == ST_BUSY) begin
      rsp_o <= rsp_d;
    end
  end

  assign ack_o = (state_q == ST_DONE);

  // ---------------------------------------------------------------------------
  // datapath
  // ---------------------------------------------------------------------------
  fpu_recode_in u_rec_rs1 (.in_i(req_q.rs1), .rec_o(rs1_rec));
  fpu_recode_in u_rec_rs2 (.in_i(req_q.rs2), .rec_o(rs2_rec));

  // flt/fle signal on any nan, feq only on snan
  assign cmp_signaling = (req_q.op == FLT) || (req_q.op == FLE);
  assign fmin_sel      = (req_q.op == FMIN);

  fpu_compare_rec u_cmp (
    .a_i         (rs1_rec),
    .b_i         (rs2_rec),
    .signaling_i (cmp_signaling),
    .lt_o        (cmp_lt),
    .eq_o        (cmp_eq),
    .unordered_o (),
    .invalid_o   (cmp_invalid)
  );

  fpu_fmin_fmax u_minmax (
    .fp_rs1_i  (rs1_rec),
    .fp_rs2_i  (rs2_rec),
    .fmin_i    (fmin_sel),
    .invalid_o (minmax_invalid),
    .result_o  (minmax_rec)
  );

  fpu_recode_out u_rec_out (.rec_i(minmax_rec), .out_o(minmax_word));

  // op mux into the result union
  always_comb begin
    rsp_d = '0;
    case (req_q.op)
      FMIN, FMAX: begin
        rsp_d.result.flt = fpu_float_t'(minmax_word);
        rsp_d.invalid    = minmax_invalid;
      end
      FEQ: begin
        rsp_d.result.uint[0] = cmp_eq;
        rsp_d.invalid        = cmp_invalid;
      end
      FLT: begin
        rsp_d.result.uint[0] = cmp_lt;
        rsp_d.invalid        = cmp_invalid;
      end
      FLE: begin
        rsp_d.result.uint[0] = cmp_lt | cmp_eq;
        rsp_d.invalid        = cmp_invalid;
      end
      default: rsp_d = '0;
    endcase
  end

endmodule

// File: fpu_recode_out.sv
// recoded form back to binary32, purely combinational
// exponents below the normal range come out as subnormals
// nan keeps its fraction, so the recoded canonical nan maps to 0x7fc00000

`timescale 1ns/1ns
`include "fpu_settings.svh"

module fpu_recode_out (
  input  fpu_types_pkg::rec_num_t                  rec_i,
  output logic [`FPU_EXP_WIDTH+`FPU_SIG_WIDTH-1:0] out_o
);

  // smallest recoded exponent of a normal number
  localparam logic [`FPU_EXP_WIDTH:0] min_norm_exp = (1 << (`FPU_EXP_WIDTH-1)) + 2;
  localparam logic [`FPU_EXP_WIDTH:0] exp_bias     = (1 << (`FPU_EXP_WIDTH-1)) + 1;

  logic [2:0]                cls;
  logic                      is_sub;
  logic [`FPU_EXP_WIDTH:0]   denorm_shift;
  logic [`FPU_SIG_WIDTH-1:0] sig_shifted;
  logic [`FPU_EXP_WIDTH-1:0] exp_out;

  assign cls    = rec_i.exp[`FPU_EXP_WIDTH -: 3];
  assign is_sub = (rec_i.exp < min_norm_exp);

  // hidden one goes back in, then right shift into subnormal position
  assign denorm_shift = min_norm_exp - rec_i.exp;
  assign sig_shifted  = {1'b1, rec_i.frac} >> denorm_shift;

  // modulo 2^ew, upper bit of the recoded exponent drops out
  assign exp_out = rec_i.exp[`FPU_EXP_WIDTH-1:0] - exp_bias[`FPU_EXP_WIDTH-1:0];

  always_comb begin
    out_o = '0;
    out_o[`FPU_EXP_WIDTH+`FPU_SIG_WIDTH-1] = rec_i.sign;
    if (cls == 3'b111) begin
      // nan
      out_o[`FPU_SIG_WIDTH-1 +: `FPU_EXP_WIDTH] = '1;
      out_o[`FPU_SIG_WIDTH-2:0]                 = rec_i.frac;
    end else if (cls == 3'b110) begin
      // infinity
      out_o[`FPU_SIG_WIDTH-1 +: `FPU_EXP_WIDTH] = '1;
    end else if (cls == 3'b000) begin
      // signed zero, only the sign survives
      out_o[`FPU_SIG_WIDTH-2:0] = '0;
    end else if (is_sub) begin
      out_o[`FPU_SIG_WIDTH-2:0] = sig_shifted[`FPU_SIG_WIDTH-2:0];
    end else begin
      out_o[`FPU_SIG_WIDTH-1 +: `FPU_EXP_WIDTH] = exp_out;
      out_o[`FPU_SIG_WIDTH-2:0]                 = rec_i.frac;
    end
  end

endmodule

// File: fpu_fmin_fmax.sv
// fmin / fmax on recoded operands, purely combinational
// -0.0 counts as below +0.0, two nans give the canonical nan,
// one nan gives the other operand, a signaling nan flags invalid

`timescale 1ns/1ns
`include "fpu_settings.svh"

module fpu_fmin_fmax (
  input  fpu_types_pkg::rec_num_t fp_rs1_i,
  input  fpu_types_pkg::rec_num_t fp_rs2_i,
  // 1 selects fmin, 0 fmax
  input  logic                    fmin_i,
  output logic                    invalid_o,
  output fpu_types_pkg::rec_num_t result_o
);

  import fpu_types_pkg::*;

  logic rs1_is_nan;
  logic rs2_is_nan;
  logic rs1_is_snan;
  logic rs2_is_snan;
  logic cmp_lt;
  logic cmp_eq;
  logic zero_diff_sign;

  assign rs1_is_nan  = &fp_rs1_i.exp[`FPU_EXP_WIDTH -: 3];
  assign rs2_is_nan  = &fp_rs2_i.exp[`FPU_EXP_WIDTH -: 3];
  assign rs1_is_snan = rs1_is_nan & ~fp_rs1_i.frac[`FPU_SIG_WIDTH-2];
  assign rs2_is_snan = rs2_is_nan & ~fp_rs2_i.frac[`FPU_SIG_WIDTH-2];

  // quiet compare, only ordering needed here
  fpu_compare_rec u_cmp (
    .a_i         (fp_rs1_i),
    .b_i         (fp_rs2_i),
    .signaling_i (1'b0),
    .lt_o        (cmp_lt),
    .eq_o        (cmp_eq),
    .unordered_o (),
    .invalid_o   ()
  );

  // equal with opposite signs can only be +0 vs -0
  assign zero_diff_sign = cmp_eq & (fp_rs1_i.sign ^ fp_rs2_i.sign);

  // ---------------------------------------------------------------------------
  // select, nan priority first
  // ---------------------------------------------------------------------------
  always_comb begin
    if (rs1_is_nan && rs2_is_nan) begin
      result_o = REC_CANON_NAN;
    end else if (rs1_is_nan) begin
      result_o = fp_rs2_i;
    end else if (rs2_is_nan) begin
      result_o = fp_rs1_i;
    end else if (zero_diff_sign) begin
      // min wants the negative zero, max the positive one
      result_o = (fmin_i ^ fp_rs1_i.sign) ? fp_rs2_i : fp_rs1_i;
    end else begin
      // lt & min -> rs1, ~lt & max -> rs1
      result_o = (cmp_lt ^ fmin_i) ? fp_rs2_i : fp_rs1_i;
    end
  end

  // flagged even when the result is the other operand
  assign invalid_o = rs1_is_snan | rs2_is_snan;

endmodule

// File: fpu_compare_rec.sv
// ordered compare of two recoded numbers, purely combinational
// signaling_i high: any nan is invalid (flt/fle)
// signaling_i low: only a signaling nan is invalid (feq, min/max)

`timescale 1ns/1ns
`include "fpu_settings.svh"

module fpu_compare_rec (
  input  fpu_types_pkg::rec_num_t a_i,
  input  fpu_types_pkg::rec_num_t b_i,
  input  logic                    signaling_i,
  output logic                    lt_o,
  output logic                    eq_o,
  output logic                    unordered_o,
  output logic                    invalid_o
);

  logic a_nan;
  logic b_nan;
  logic a_snan;
  logic b_snan;
  logic a_zero;
  logic b_zero;
  // magnitude as one unsigned word, exponent above fraction
  logic [`FPU_EXP_WIDTH+`FPU_SIG_WIDTH-1:0] a_mag;
  logic [`FPU_EXP_WIDTH+`FPU_SIG_WIDTH-1:0] b_mag;
  logic lt_raw;
  logic eq_raw;

  // class from the top three exponent bits
  assign a_nan  = &a_i.exp[`FPU_EXP_WIDTH -: 3];
  assign b_nan  = &b_i.exp[`FPU_EXP_WIDTH -: 3];
  assign a_zero = (a_i.exp[`FPU_EXP_WIDTH -: 3] == 3'b000);
  assign b_zero = (b_i.exp[`FPU_EXP_WIDTH -: 3] == 3'b000);
  // quiet bit clear means signaling
  assign a_snan = a_nan & ~a_i.frac[`FPU_SIG_WIDTH-2];
  assign b_snan = b_nan & ~b_i.frac[`FPU_SIG_WIDTH-2];

  // zero low bits of the exponent do not matter, flatten to 0
  assign a_mag = a_zero ? '0 : {a_i.exp, a_i.frac};
  assign b_mag = b_zero ? '0 : {b_i.exp, b_i.frac};

  // sign first, then magnitude, reversed for two negatives
  always_comb begin
    if (a_zero && b_zero) begin
      // +0 == -0
      lt_raw = 1'b0;
      eq_raw = 1'b1;
    end else if (a_i.sign != b_i.sign) begin
      lt_raw = a_i.sign;
      eq_raw = 1'b0;
    end else if (a_i.sign) begin
      lt_raw = (a_mag > b_mag);
      eq_raw = (a_mag == b_mag);
    end else begin
      lt_raw = (a_mag < b_mag);
      eq_raw = (a_mag == b_mag);
    end
  end

  // nan kills the ordering
  assign unordered_o = a_nan | b_nan;
  assign lt_o        = lt_raw & ~unordered_o;
  assign eq_o        = eq_raw & ~unordered_o;
  assign invalid_o   = signaling_i ? unordered_o : (a_snan | b_snan);

endmodule

// File: fpu_recode_in.sv
// binary32 to recoded form, purely combinational
// subnormals get normalized here so later stages never see them
// nan payload passes through unchanged, quiet bit included

`timescale 1ns/1ns
`include "fpu_settings.svh"

module fpu_recode_in (
  input  logic [`FPU_EXP_WIDTH+`FPU_SIG_WIDTH-1:0] in_i,
  output fpu_types_pkg::rec_num_t                  rec_o
);

  // leading-zero count width over the fraction
  localparam int unsigned lzc_w = $clog2(`FPU_SIG_WIDTH-1);
  // 2^(ew-1) + 1, added to the ieee exponent
  localparam logic [`FPU_EXP_WIDTH:0] exp_bias = (1 << (`FPU_EXP_WIDTH-1)) + 1;

  logic                      sign;
  logic [`FPU_EXP_WIDTH-1:0] exp_in;
  logic [`FPU_SIG_WIDTH-2:0] frac_in;
  logic                      exp_zero;
  logic                      exp_ones;
  logic                      frac_zero;
  logic [lzc_w-1:0]          norm_dist;

  assign sign      = in_i[`FPU_EXP_WIDTH+`FPU_SIG_WIDTH-1];
  assign exp_in    = in_i[`FPU_SIG_WIDTH-1 +: `FPU_EXP_WIDTH];
  assign frac_in   = in_i[`FPU_SIG_WIDTH-2:0];
  assign exp_zero  = (exp_in == '0);
  assign exp_ones  = &exp_in;
  assign frac_zero = (frac_in == '0);

  // leading zeros of the fraction
  // highest set bit wins since it is written last
  always_comb begin
    norm_dist = '0;
    for (int i = 0; i < `FPU_SIG_WIDTH-1; i++) begin
      if (frac_in[i]) begin
        norm_dist = lzc_w'(`FPU_SIG_WIDTH-2-i);
      end
    end
  end

  // ---------------------------------------------------------------------------
  // class decode and exponent rebias
  // ---------------------------------------------------------------------------
  always_comb begin
    rec_o.sign = sign;
    if (exp_ones && !frac_zero) begin
      // nan, keep payload
      rec_o.exp  = {3'b111, {(`FPU_EXP_WIDTH-2){1'b0}}};
      rec_o.frac = frac_in;
    end else if (exp_ones) begin
      // infinity
      rec_o.exp  = {3'b110, {(`FPU_EXP_WIDTH-2){1'b0}}};
      rec_o.frac = '0;
    end else if (exp_zero && frac_zero) begin
      // signed zero, class bits 000
      rec_o.exp  = '0;
      rec_o.frac = '0;
    end else if (exp_zero) begin
      // subnormal: shift out the leading one, lower the exponent to match
      rec_o.exp  = exp_bias - {{(`FPU_EXP_WIDTH+1-lzc_w){1'b0}}, norm_dist};
      rec_o.frac = frac_in << (norm_dist + 1);
    end else begin
      rec_o.exp  = {1'b0, exp_in} + exp_bias;
      rec_o.frac = frac_in;
    end
  end

endmodule

// File: fpu_io_pkg.sv
// request and response formats at the ports of the compare unit
// the result word is read as a float for min/max, as an integer otherwise

`include "fpu_settings.svh"

package fpu_io_pkg;

  // one operation, held stable by the requester while req is high
  typedef struct packed {
    fpu_types_pkg::fpu_op_e                       op;
    logic [`FPU_EXP_WIDTH+`FPU_SIG_WIDTH-1:0]     rs1;
    logic [`FPU_EXP_WIDTH+`FPU_SIG_WIDTH-1:0]     rs2;
  } fpu_req_t;

  // ieee field view of the result
  typedef struct packed {
    logic                      sign;
    logic [`FPU_EXP_WIDTH-1:0] exp;
    logic [`FPU_SIG_WIDTH-2:0] frac;
  } fpu_float_t;

  // float view for fmin/fmax, int view for feq/flt/fle
  typedef union packed {
    fpu_float_t                               flt;
    logic [`FPU_EXP_WIDTH+`FPU_SIG_WIDTH-1:0] uint;
  } fpu_result_u;

  typedef struct packed {
    fpu_result_u result;
    logic        invalid;
  } fpu_rsp_t;

endpackage

// File: fpu_types_pkg.sv
// number formats and opcodes shared by the compare datapath
// recoded form: sign, widened exponent, fraction without hidden bit
// exponent top three bits give the class: 000 zero, 110 inf, 111 nan

`include "fpu_settings.svh"

package fpu_types_pkg;

  // -------------------------------------------------------------------------
  // recoded number
  // -------------------------------------------------------------------------

  // exp holds biased exponent + 2^(ew-1) + 1 for normals
  // subnormals are normalized, so their exp sits just below the normal range
  typedef struct packed {
    logic                      sign;
    logic [`FPU_EXP_WIDTH:0]   exp;
    logic [`FPU_SIG_WIDTH-2:0] frac;
  } rec_num_t;

  // -------------------------------------------------------------------------
  // operations
  // -------------------------------------------------------------------------

  // min/max return a float, the rest return 0 or 1
  typedef enum logic [2:0] {FMIN, FMAX, FEQ, FLT, FLE} fpu_op_e;

  // -------------------------------------------------------------------------
  // constants
  // -------------------------------------------------------------------------

  // canonical quiet nan in recoded form
  // nan class bits, quiet bit set, rest of payload clear
  localparam rec_num_t REC_CANON_NAN = '{
    sign: 1'b0,
    exp:  {3'b111, {(`FPU_EXP_WIDTH-2){1'b0}}},
    frac: {1'b1, {(`FPU_SIG_WIDTH-2){1'b0}}}
  };

endpackage

// File: fpu_settings.svh
// format widths for the floating-point compare unit
// include wherever a width of the ieee word or the recoded word is needed
// recoded width is exp + sig + 1, ieee width is exp + sig

`ifndef FPU_SETTINGS_SVH
`define FPU_SETTINGS_SVH

// ---------------------------------------------------------------------------
// binary32
// ---------------------------------------------------------------------------

// exponent field of the ieee word
`define FPU_EXP_WIDTH 8

// significand incl. the hidden bit
`define FPU_SIG_WIDTH 24

// recoded exponent gets one extra bit on top of FPU_EXP_WIDTH

`endif
